// File: common/i3c_settings.svh
// bus widths, FIFO depths and reset clock divider for the I3C controller
`ifndef I3C_SETTINGS_SVH
`define I3C_SETTINGS_SVH

// AHB-Lite port widths
`define I3C_AHB_ADDR_WIDTH 32
`define I3C_AHB_DATA_WIDTH 32

// queue depths, in entries
`define I3C_CMD_FIFO_DEPTH 4
`define I3C_RX_FIFO_DEPTH  4

// clock cycles per SCL quarter period after reset
`define I3C_CLKDIV_RESET 4

`endif

// File: common/i3c_pkg.sv
// command opcode, command word, register offsets and STATUS bit positions
`default_nettype none

package i3c_pkg;

  // bus operations executed by the bit engine
  typedef enum logic [1:0] {
    OP_START = 2'd0,
    OP_WRITE = 2'd1,
    OP_READ  = 2'd2,
    OP_STOP  = 2'd3
  } i3c_op_e;

  // matches the CMD register write layout, bit 10 down to bit 0
  typedef struct packed {
    logic    last;  // read only: reply NACK instead of ACK
    i3c_op_e op;
    logic [7:0] data;
  } i3c_cmd_t;

  // byte offsets of the host registers
  typedef enum logic [4:0] {
    REG_CTRL    = 5'h00,
    REG_CLKDIV  = 5'h04,
    REG_CMD     = 5'h08,
    REG_RX_DATA = 5'h0C,
    REG_STATUS  = 5'h10
  } i3c_reg_e;

  // STATUS register bits
  localparam int unsigned STAT_CMD_EMPTY    = 0;
  localparam int unsigned STAT_CMD_FULL     = 1;
  localparam int unsigned STAT_RX_EMPTY     = 2;
  localparam int unsigned STAT_RX_FULL      = 3;
  localparam int unsigned STAT_BUSY         = 4;
  localparam int unsigned STAT_NACK         = 5;  // sticky, write 1 to clear
  localparam int unsigned STAT_CMD_OVERFLOW = 6;  // sticky, write 1 to clear
  localparam int unsigned STAT_WIDTH        = 7;

endpackage

`default_nettype wire

// File: logic/sync_fifo.sv
// synchronous show-ahead FIFO with a configurable payload type
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter type         payload_t = logic [7:0],
  parameter int unsigned DEPTH     = 4
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     push_i,
  input  payload_t wdata_i,
  input  logic     pop_i,
  output payload_t rdata_o,
  output logic     full_o,
  output logic     empty_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  payload_t         mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  // wraps at DEPTH, so depths other than powers of two work
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);
  assign do_push = push_i && !full_o;  // push while full is ignored
  assign do_pop  = pop_i && !empty_o;
  assign rdata_o = mem_q[rd_ptr_q];     // head entry, show-ahead

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= wdata_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // none, or both at once
      endcase
    end
  end

endmodule

`default_nettype wire

// File: ahb/ahb_csr_slave.sv
// AHB-Lite slave with CTRL, CLKDIV, CMD, RX_DATA and STATUS registers
`timescale 1ns/1ps
`include "i3c_settings.svh"
`default_nettype none

module ahb_csr_slave
  import i3c_pkg::*;
(
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic [`I3C_AHB_ADDR_WIDTH-1:0] haddr_i,
  input  logic [1:0]                     htrans_i,
  input  logic [2:0]                     hsize_i,
  input  logic                           hwrite_i,
  input  logic [`I3C_AHB_DATA_WIDTH-1:0] hwdata_i,
  input  logic                           hsel_i,
  input  logic                           hready_i,
  output logic [`I3C_AHB_DATA_WIDTH-1:0] hrdata_o,
  output logic                           hreadyout_o,
  output logic                           hresp_o,
  input  logic                           cmd_full_i,
  input  logic                           cmd_empty_i,
  input  logic                           rx_empty_i,
  input  logic                           rx_full_i,
  input  logic [7:0]                     rx_rdata_i,
  input  logic                           busy_i,
  input  logic                           nack_pulse_i,
  output logic                           cmd_push_o,
  output i3c_cmd_t                       cmd_wdata_o,
  output logic                           rx_pop_o,
  output logic                           enable_o,
  output logic [15:0]                    clkdiv_o
);

  logic                  dph_valid_q;  // data phase in progress
  logic                  dph_write_q;
  logic [4:0]            dph_addr_q;
  i3c_reg_e              dph_reg;
  logic                  aph_take;
  logic                  wr_en;
  logic                  rd_en;
  logic                  enable_q;
  logic [15:0]           clkdiv_q;
  logic                  nack_q;
  logic                  ovf_q;
  logic                  cmd_wr;
  logic                  status_wr;
  logic [STAT_WIDTH-1:0] status;

  // NONSEQ or SEQ, up to word size
  assign aph_take = hsel_i && hready_i && htrans_i[1] && (hsize_i <= 3'd2);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      dph_valid_q <= 1'b0;
    end else begin
      dph_valid_q <= aph_take;
    end
  end

  always_ff @(posedge clk_i) begin
    if (aph_take) begin
      dph_addr_q  <= haddr_i[4:0];
      dph_write_q <= hwrite_i;
    end
  end

  assign dph_reg   = i3c_reg_e'(dph_addr_q);
  assign wr_en     = dph_valid_q && dph_write_q;
  assign rd_en     = dph_valid_q && !dph_write_q;
  assign cmd_wr    = wr_en && (dph_reg == REG_CMD);
  assign status_wr = wr_en && (dph_reg == REG_STATUS);

  assign cmd_push_o  = cmd_wr && !cmd_full_i;  // dropped when full
  assign cmd_wdata_o = i3c_cmd_t'(hwdata_i[10:0]);
  assign rx_pop_o    = rd_en && (dph_reg == REG_RX_DATA) && !rx_empty_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      enable_q <= 1'b0;
      clkdiv_q <= 16'(`I3C_CLKDIV_RESET);
      nack_q   <= 1'b0;
      ovf_q    <= 1'b0;
    end else begin
      if (wr_en && (dph_reg == REG_CTRL)) begin
        enable_q <= hwdata_i[0];
      end
      if (wr_en && (dph_reg == REG_CLKDIV)) begin
        clkdiv_q <= hwdata_i[15:0];
      end
      if (nack_pulse_i) begin  // a new NACK wins over a clear
        nack_q <= 1'b1;
      end else if (status_wr && hwdata_i[STAT_NACK]) begin
        nack_q <= 1'b0;
      end
      if (cmd_wr && cmd_full_i) begin
        ovf_q <= 1'b1;
      end else if (status_wr && hwdata_i[STAT_CMD_OVERFLOW]) begin
        ovf_q <= 1'b0;
      end
    end
  end

  always_comb begin
    status                    = '0;
    status[STAT_CMD_EMPTY]    = cmd_empty_i;
    status[STAT_CMD_FULL]     = cmd_full_i;
    status[STAT_RX_EMPTY]     = rx_empty_i;
    status[STAT_RX_FULL]      = rx_full_i;
    status[STAT_BUSY]         = busy_i;
    status[STAT_NACK]         = nack_q;
    status[STAT_CMD_OVERFLOW] = ovf_q;
  end

  // read data follows the latched address within the data phase
  always_comb begin
    hrdata_o = '0;
    if (rd_en) begin
      case (dph_reg)
        REG_CTRL:    hrdata_o[0]              = enable_q;
        REG_CLKDIV:  hrdata_o[15:0]           = clkdiv_q;
        REG_RX_DATA: hrdata_o[7:0]            = rx_empty_i ? 8'h00 : rx_rdata_i;
        REG_STATUS:  hrdata_o[STAT_WIDTH-1:0] = status;
        default:     hrdata_o                 = '0;  // CMD and holes read zero
      endcase
    end
  end

  assign hreadyout_o = 1'b1;  // no wait states
  assign hresp_o     = 1'b0;  // always OKAY
  assign enable_o    = enable_q;
  assign clkdiv_o    = clkdiv_q;

endmodule

`default_nettype wire

// File: i3c/i3c_bus_engine.sv
// SCL/SDA bit engine running START, byte write, byte read and STOP
`timescale 1ns/1ps
`default_nettype none

module i3c_bus_engine
  import i3c_pkg::*;
(
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        enable_i,
  input  logic [15:0] clkdiv_i,
  input  logic        cmd_empty_i,
  input  i3c_cmd_t    cmd_rdata_i,
  input  logic        rx_full_i,
  input  logic        scl_i,
  input  logic        sda_i,
  output logic        cmd_pop_o,
  output logic        rx_push_o,
  output logic [7:0]  rx_wdata_o,
  output logic        busy_o,
  output logic        nack_pulse_o,
  output logic        scl_o,
  output logic        scl_en_o,
  output logic        sda_o,
  output logic        sda_en_o
);

  typedef enum logic [1:0] {ST_IDLE, ST_START, ST_BIT, ST_STOP} state_e;

  state_e      state_q;
  state_e      cmd_state;
  i3c_op_e     op_q;
  logic        last_q;
  logic [15:0] div_cnt_q;
  logic [1:0]  phase_q;
  logic [3:0]  bit_cnt_q;  // 0..7 data, 8 is the ACK slot
  logic [7:0]  shift_q;
  logic        scl_en_q;
  logic        sda_en_q;
  logic        nack_q;
  logic [15:0] div_max;
  logic        phase_end;
  logic        cmd_ok;
  logic        ack_slot;
  logic        sample;
  logic        bit_end;
  logic        sda_next;

  assign div_max   = (clkdiv_i == 16'd0) ? 16'd0 : clkdiv_i - 16'd1;
  assign phase_end = (div_cnt_q >= div_max);
  assign ack_slot  = (bit_cnt_q == 4'd8);

  // reads wait for room in the receive FIFO
  assign cmd_ok    = enable_i && !cmd_empty_i &&
                     ((cmd_rdata_i.op != OP_READ) || !rx_full_i);
  assign cmd_pop_o = (state_q == ST_IDLE) && cmd_ok;

  assign sample  = (state_q == ST_BIT) && (phase_q == 2'd2) && phase_end && scl_i;
  assign bit_end = (state_q == ST_BIT) && (phase_q == 2'd3) && phase_end;

  assign rx_push_o    = bit_end && ack_slot && (op_q == OP_READ);
  assign rx_wdata_o   = shift_q;
  assign busy_o       = (state_q != ST_IDLE) || cmd_pop_o;
  assign nack_pulse_o = nack_q;

  // open drain, only ever pulls low
  assign scl_o    = 1'b0;
  assign sda_o    = 1'b0;
  assign scl_en_o = scl_en_q;
  assign sda_en_o = sda_en_q;

  always_comb begin
    case (cmd_rdata_i.op)
      OP_START: cmd_state = ST_START;
      OP_STOP:  cmd_state = ST_STOP;
      default:  cmd_state = ST_BIT;
    endcase
  end

  // SDA enable for the bit that follows the current one
  always_comb begin
    if (bit_cnt_q == 4'd7) begin
      sda_next = (op_q == OP_READ) && !last_q;  // ACK unless last read
    end else begin
      sda_next = (op_q == OP_WRITE) && !shift_q[6];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q   <= ST_IDLE;
      div_cnt_q <= '0;
      phase_q   <= '0;
      bit_cnt_q <= '0;
    end else if (state_q == ST_IDLE) begin
      if (cmd_ok) begin
        state_q   <= cmd_state;
        div_cnt_q <= '0;
        phase_q   <= '0;
        bit_cnt_q <= '0;
      end
    end else if (phase_end) begin
      div_cnt_q <= '0;
      phase_q   <= phase_q + 2'd1;
      if (phase_q == 2'd3) begin
        if ((state_q != ST_BIT) || ack_slot) begin
          state_q <= ST_IDLE;
        end else begin
          bit_cnt_q <= bit_cnt_q + 4'd1;
        end
      end
    end else begin
      div_cnt_q <= div_cnt_q + 16'd1;
    end
  end

  // line drive changes on entry to each phase and holds while idle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      scl_en_q <= 1'b0;
      sda_en_q <= 1'b0;
    end else if (cmd_pop_o) begin
      case (cmd_rdata_i.op)
        OP_START: sda_en_q <= 1'b0;  // SDA up before SCL is released
        OP_WRITE: begin
          scl_en_q <= 1'b1;
          sda_en_q <= !cmd_rdata_i.data[7];
        end
        OP_READ: begin
          scl_en_q <= 1'b1;
          sda_en_q <= 1'b0;
        end
        default: begin  // stop: both low first
          scl_en_q <= 1'b1;
          sda_en_q <= 1'b1;
        end
      endcase
    end else if ((state_q != ST_IDLE) && phase_end) begin
      case (phase_q)
        2'd0: scl_en_q <= 1'b0;  // SCL rises
        2'd1: begin
          if (state_q == ST_START) begin
            sda_en_q <= 1'b1;  // SDA falls while SCL high
          end else if (state_q == ST_STOP) begin
            sda_en_q <= 1'b0;  // SDA rises while SCL high
          end
        end
        2'd2: begin
          if (state_q != ST_STOP) begin
            scl_en_q <= 1'b1;
          end
        end
        default: begin
          if ((state_q == ST_BIT) && !ack_slot) begin
            sda_en_q <= sda_next;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_pop_o) begin
      shift_q <= cmd_rdata_i.data;
      op_q    <= cmd_rdata_i.op;
      last_q  <= cmd_rdata_i.last;
    end else if (sample && !ack_slot && (op_q == OP_READ)) begin
      shift_q <= {shift_q[6:0], sda_i};  // MSB first
    end else if (bit_end && !ack_slot && (op_q == OP_WRITE)) begin
      shift_q <= {shift_q[6:0], 1'b0};
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      nack_q <= 1'b0;
    end else begin
      nack_q <= sample && ack_slot && (op_q == OP_WRITE) && sda_i;
    end
  end

endmodule

`default_nettype wire

// File: logic/i3c_phy_integration_wrapper.sv
// top level with register block, command and receive FIFOs, bit engine and pad loopback
`timescale 1ns/1ps
`include "i3c_settings.svh"
`default_nettype none

module i3c_phy_integration_wrapper
  import i3c_pkg::*;
(
  input  logic                           clk_i,
  input  logic                           reset_i,

  input  logic                           i3c_scl_i,
  output logic                           i3c_scl_o,
  output logic                           i3c_scl_en_o,
  input  logic                           i3c_sda_i,
  output logic                           i3c_sda_o,
  output logic                           i3c_sda_en_o,

  input  logic [`I3C_AHB_ADDR_WIDTH-1:0] haddr_i,
  input  logic [1:0]                     htrans_i,
  input  logic [2:0]                     hsize_i,
  input  logic                           hwrite_i,
  input  logic [`I3C_AHB_DATA_WIDTH-1:0] hwdata_i,
  input  logic                           hsel_i,
  input  logic                           hready_i,
  output logic [`I3C_AHB_DATA_WIDTH-1:0] hrdata_o,
  output logic                           hreadyout_o,
  output logic                           hresp_o
);

  logic        cmd_push;
  i3c_cmd_t    cmd_wdata;
  logic        cmd_pop;
  i3c_cmd_t    cmd_rdata;
  logic        cmd_full;
  logic        cmd_empty;
  logic        rx_push;
  logic [7:0]  rx_wdata;
  logic        rx_pop;
  logic [7:0]  rx_rdata;
  logic        rx_full;
  logic        rx_empty;
  logic        enable;
  logic [15:0] clkdiv;
  logic        busy;
  logic        nack_pulse;
  logic        scl_int;
  logic        sda_int;

  // pads echo the bus while the engine is not driving
  assign i3c_scl_o = i3c_scl_en_o ? scl_int : i3c_scl_i;
  assign i3c_sda_o = i3c_sda_en_o ? sda_int : i3c_sda_i;

  ahb_csr_slave csr0 (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .haddr_i      (haddr_i),
    .htrans_i     (htrans_i),
    .hsize_i      (hsize_i),
    .hwrite_i     (hwrite_i),
    .hwdata_i     (hwdata_i),
    .hsel_i       (hsel_i),
    .hready_i     (hready_i),
    .hrdata_o     (hrdata_o),
    .hreadyout_o  (hreadyout_o),
    .hresp_o      (hresp_o),
    .cmd_full_i   (cmd_full),
    .cmd_empty_i  (cmd_empty),
    .rx_empty_i   (rx_empty),
    .rx_full_i    (rx_full),
    .rx_rdata_i   (rx_rdata),
    .busy_i       (busy),
    .nack_pulse_i (nack_pulse),
    .cmd_push_o   (cmd_push),
    .cmd_wdata_o  (cmd_wdata),
    .rx_pop_o     (rx_pop),
    .enable_o     (enable),
    .clkdiv_o     (clkdiv)
  );

  sync_fifo #(
    .payload_t (i3c_cmd_t),
    .DEPTH     (`I3C_CMD_FIFO_DEPTH)
  ) cmd_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .push_i  (cmd_push),
    .wdata_i (cmd_wdata),
    .pop_i   (cmd_pop),
    .rdata_o (cmd_rdata),
    .full_o  (cmd_full),
    .empty_o (cmd_empty)
  );

  sync_fifo #(
    .payload_t (logic [7:0]),
    .DEPTH     (`I3C_RX_FIFO_DEPTH)
  ) rx_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .push_i  (rx_push),
    .wdata_i (rx_wdata),
    .pop_i   (rx_pop),
    .rdata_o (rx_rdata),
    .full_o  (rx_full),
    .empty_o (rx_empty)
  );

  i3c_bus_engine engine0 (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .enable_i     (enable),
    .clkdiv_i     (clkdiv),
    .cmd_empty_i  (cmd_empty),
    .cmd_rdata_i  (cmd_rdata),
    .rx_full_i    (rx_full),
    .scl_i        (i3c_scl_i),
    .sda_i        (i3c_sda_i),
    .cmd_pop_o    (cmd_pop),
    .rx_push_o    (rx_push),
    .rx_wdata_o   (rx_wdata),
    .busy_o       (busy),
    .nack_pulse_o (nack_pulse),
    .scl_o        (scl_int),
    .scl_en_o     (i3c_scl_en_o),
    .sda_o        (sda_int),
    .sda_en_o     (i3c_sda_en_o)
  );

endmodule

`default_nettype wire

// File: tests/i3c_target_model.sv
// behavioral I2C target with an 8-byte memory and an auto-incrementing pointer
`timescale 1ns/1ps
`default_nettype none

module i3c_target_model #(
  parameter logic [6:0] ADDR = 7'h50
) (
  input  logic scl_i,
  input  logic sda_i,
  output logic sda_o  // 0 pulls SDA low, 1 releases it
);

  typedef enum logic [1:0] {T_IDLE, T_ADDR, T_WRITE, T_READ} tstate_e;

  tstate_e    state;
  logic [7:0] mem [8];
  logic [2:0] ptr;
  logic [3:0] bit_cnt;   // SCL rising edges seen in the current byte
  logic [7:0] shreg;
  logic       scl_prev;
  logic       sda_prev;
  logic       rd_mode;
  logic       host_ack;

  initial begin
    state    = T_IDLE;
    sda_o    = 1'b1;
    ptr      = '0;
    bit_cnt  = '0;
    shreg    = '0;
    rd_mode  = 1'b0;
    host_ack = 1'b0;
    for (int i = 0; i < 8; i++) begin
      mem[i] = 8'hE0 | 8'(i);  // fill differs per address
    end
  end

  always @(scl_i or sda_i) begin
    if (scl_i && scl_prev && sda_prev && !sda_i) begin  // START
      state   = T_ADDR;
      bit_cnt = '0;
      ptr     = '0;
      sda_o   = 1'b1;
    end else if (scl_i && scl_prev && !sda_prev && sda_i) begin  // STOP
      state = T_IDLE;
      sda_o = 1'b1;
    end else if (scl_i && !scl_prev && (state != T_IDLE)) begin
      if ((bit_cnt < 4'd8) && (state != T_READ)) begin
        shreg = {shreg[6:0], sda_i};  // MSB first
      end else if ((bit_cnt == 4'd8) && (state == T_READ)) begin
        host_ack = !sda_i;
      end
      bit_cnt = bit_cnt + 4'd1;
    end else if (!scl_i && scl_prev && (state != T_IDLE)) begin
      if (bit_cnt == 4'd8) begin  // ACK slot starts
        case (state)
          T_ADDR: begin
            if (shreg[7:1] == ADDR) begin
              sda_o   = 1'b0;
              rd_mode = shreg[0];
            end else begin
              state = T_IDLE;  // not ours, stay off the bus
            end
          end
          T_WRITE: begin
            mem[ptr] = shreg;
            ptr      = ptr + 3'd1;
            sda_o    = 1'b0;
          end
          default: sda_o = 1'b1;  // controller answers
        endcase
      end else if (bit_cnt == 4'd9) begin  // byte done
        bit_cnt = '0;
        sda_o   = 1'b1;
        if (state == T_ADDR) begin
          state = rd_mode ? T_READ : T_WRITE;
        end else if ((state == T_READ) && !host_ack) begin
          state = T_IDLE;
        end
        if (state == T_READ) begin
          shreg = mem[ptr];
          ptr   = ptr + 3'd1;
          sda_o = shreg[7];
        end
      end else if ((state == T_READ) && (bit_cnt != 4'd0)) begin
        sda_o = shreg[7 - bit_cnt];
      end
    end
    scl_prev = scl_i;
    sda_prev = sda_i;
  end

endmodule

`default_nettype wire

// File: tests/i3c_sva.sv
// concurrent assertions on the bit engine reset state and FIFO strobes
`timescale 1ns/1ps
`default_nettype none

module i3c_engine_sva (
  input logic clk_i,
  input logic reset_i,
  input logic scl_en_i,
  input logic sda_en_i,
  input logic cmd_pop_i,
  input logic cmd_empty_i,
  input logic rx_push_i,
  input logic rx_full_i
);

  int unsigned failures = 0;  // assertion failures so far

  // both lines released once reset has been seen
  enables_low_after_reset: assert property (
    @(posedge clk_i) reset_i |=> (!scl_en_i && !sda_en_i)
  ) else begin
    $error("bus enables still set in the cycle after reset");
    failures++;
  end

  pop_only_when_filled: assert property (
    @(posedge clk_i) disable iff (reset_i) cmd_empty_i |-> !cmd_pop_i
  ) else begin
    $error("command pop while the command FIFO is empty");
    failures++;
  end

  push_only_with_room: assert property (
    @(posedge clk_i) disable iff (reset_i) rx_full_i |-> !rx_push_i
  ) else begin
    $error("receive push while the receive FIFO is full");
    failures++;
  end

endmodule

bind i3c_bus_engine i3c_engine_sva sva0 (
  .clk_i       (clk_i),
  .reset_i     (reset_i),
  .scl_en_i    (scl_en_o),
  .sda_en_i    (sda_en_o),
  .cmd_pop_i   (cmd_pop_o),
  .cmd_empty_i (cmd_empty_i),
  .rx_push_i   (rx_push_o),
  .rx_full_i   (rx_full_i)
);

`default_nettype wire

// File: tests/i3c_tb.sv
// testbench top with clock, reset, AHB tasks, wired-AND bus, reference model and tests
`timescale 1ns/1ps
`include "i3c_settings.svh"
`default_nettype none

module i3c_tb
  import i3c_pkg::*;
();

  localparam int unsigned POLL_LIMIT = 2000;

  logic                           clk;
  logic                           reset;
  logic [`I3C_AHB_ADDR_WIDTH-1:0] haddr;
  logic [1:0]                     htrans;
  logic [2:0]                     hsize;
  logic                           hwrite;
  logic [`I3C_AHB_DATA_WIDTH-1:0] hwdata;
  logic                           hsel;
  logic                           hready;
  logic [`I3C_AHB_DATA_WIDTH-1:0] hrdata;
  logic                           hreadyout;
  logic                           hresp;
  logic                           scl_out;
  logic                           scl_en;
  logic                           sda_out;
  logic                           sda_en;
  logic                           tgt_sda;
  wire                            scl_line;
  wire                            sda_line;

  int unsigned checks;
  int unsigned errors;
  int unsigned tests;
  logic        aborted;  // a wait timed out, the rest of the run is skipped
  logic [7:0]  written [$];

  // open-drain lines with pull-ups
  assign scl_line = scl_en ? scl_out : 1'b1;
  assign sda_line = (sda_en ? sda_out : 1'b1) & tgt_sda;

  i3c_phy_integration_wrapper dut0 (
    .clk_i        (clk),
    .reset_i      (reset),
    .i3c_scl_i    (scl_line),
    .i3c_scl_o    (scl_out),
    .i3c_scl_en_o (scl_en),
    .i3c_sda_i    (sda_line),
    .i3c_sda_o    (sda_out),
    .i3c_sda_en_o (sda_en),
    .haddr_i      (haddr),
    .htrans_i     (htrans),
    .hsize_i      (hsize),
    .hwrite_i     (hwrite),
    .hwdata_i     (hwdata),
    .hsel_i       (hsel),
    .hready_i     (hready),
    .hrdata_o     (hrdata),
    .hreadyout_o  (hreadyout),
    .hresp_o      (hresp)
  );

  i3c_target_model #(.ADDR(7'h50)) tgt0 (
    .scl_i (scl_line),
    .sda_i (sda_line),
    .sda_o (tgt_sda)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic ahb_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk);
    haddr  <= addr;
    htrans <= 2'b10;  // NONSEQ
    hwrite <= 1'b1;
    hsel   <= 1'b1;
    @(posedge clk);
    htrans <= 2'b00;
    hsel   <= 1'b0;
    hwrite <= 1'b0;
    hwdata <= data;
  endtask

  task automatic ahb_read(input logic [31:0] addr, output logic [31:0] data);
    @(posedge clk);
    haddr  <= addr;
    htrans <= 2'b10;
    hwrite <= 1'b0;
    hsel   <= 1'b1;
    @(posedge clk);
    htrans <= 2'b00;
    hsel   <= 1'b0;
    @(negedge clk);
    data = hrdata;  // mid data phase
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (aborted) begin
      return;
    end
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  // polls STATUS until the masked bits match
  task automatic wait_status(input logic [31:0] mask, input logic [31:0] want,
                             input string what);
    logic [31:0] st;
    int unsigned polls;
    if (aborted) begin
      return;
    end
    polls = 0;
    ahb_read(32'(REG_STATUS), st);
    while (((st & mask) != want) && (polls < POLL_LIMIT)) begin
      ahb_read(32'(REG_STATUS), st);
      polls++;
    end
    if ((st & mask) != want) begin
      $display("timeout at %0t ns while waiting for %s", $time, what);
      errors++;
      aborted = 1'b1;
    end
  endtask

  task automatic push_cmd(input i3c_op_e op, input logic [7:0] data, input logic last);
    wait_status(32'h02, 32'h00, "room in the command FIFO");
    ahb_write(32'(REG_CMD), {21'd0, last, op, data});
  endtask

  task automatic wait_idle();
    wait_status(32'h11, 32'h01, "the engine to go idle");  // cmd_empty set, busy clear
  endtask

  function automatic logic [31:0] status_word(input logic cmd_empty, cmd_full, rx_empty,
                                              rx_full, busy, nack, ovf);
    return {25'd0, ovf, nack, busy, rx_full, rx_empty, cmd_full, cmd_empty};
  endfunction

  // the target restarts its pointer at each START, so read n returns write n
  function automatic logic [7:0] expected_read(input int unsigned idx);
    if (idx < written.size()) begin
      return written[idx];
    end
    return 8'h00;
  endfunction

  task automatic finish_test(input int unsigned num, input string name,
                             input int unsigned errs_before);
    tests++;
    $display("test %0d %s: %s", num, name, (errors == errs_before) ? "passed" : "failed");
  endtask

  task automatic check_reset_state();
    logic [31:0] rd;
    int unsigned errs;
    errs = errors;
    @(negedge clk);
    check_value("i3c_scl_en_o", 32'(scl_en), 32'd0);
    check_value("i3c_sda_en_o", 32'(sda_en), 32'd0);
    check_value("i3c_scl_o", 32'(scl_out), 32'd1);  // released line echoes the pull-up
    check_value("i3c_sda_o", 32'(sda_out), 32'd1);
    check_value("hreadyout_o", 32'(hreadyout), 32'd1);
    check_value("hresp_o", 32'(hresp), 32'd0);
    ahb_read(32'(REG_STATUS), rd);
    check_value("STATUS", rd, status_word(1, 0, 1, 0, 0, 0, 0));
    finish_test(1, "reset state", errs);
  endtask

  task automatic check_register_readback();
    logic [31:0] rd;
    int unsigned errs;
    errs = errors;
    ahb_read(32'(REG_CLKDIV), rd);
    check_value("CLKDIV", rd, 32'(`I3C_CLKDIV_RESET));
    ahb_write(32'(REG_CLKDIV), 32'h0000_1234);
    ahb_read(32'(REG_CLKDIV), rd);
    check_value("CLKDIV", rd, 32'h0000_1234);
    ahb_write(32'(REG_CTRL), 32'h1);
    ahb_read(32'(REG_CTRL), rd);
    check_value("CTRL", rd, 32'h1);
    finish_test(2, "register readback", errs);
  endtask

  task automatic write_bytes_to_target();
    logic [31:0] rd;
    logic [7:0]  b;
    int unsigned errs;
    errs = errors;
    ahb_write(32'(REG_CLKDIV), 32'd2);
    push_cmd(OP_START, 8'h00, 1'b0);
    push_cmd(OP_WRITE, 8'hA0, 1'b0);
    for (int i = 0; i < 3; i++) begin
      b = 8'($urandom());
      written.push_back(b);
      push_cmd(OP_WRITE, b, 1'b0);
    end
    push_cmd(OP_STOP, 8'h00, 1'b0);
    wait_idle();
    for (int i = 0; i < 3; i++) begin
      check_value($sformatf("target mem[%0d]", i), 32'(tgt0.mem[i]), 32'(written[i]));
    end
    ahb_read(32'(REG_STATUS), rd);
    check_value("STATUS", rd, status_word(1, 0, 1, 0, 0, 0, 0));
    finish_test(3, "write to target", errs);
  endtask

  task automatic read_bytes_from_target();
    logic [31:0] rd;
    int unsigned errs;
    errs = errors;
    push_cmd(OP_START, 8'h00, 1'b0);
    push_cmd(OP_WRITE, 8'hA1, 1'b0);
    push_cmd(OP_READ, 8'h00, 1'b0);
    push_cmd(OP_READ, 8'h00, 1'b0);
    push_cmd(OP_READ, 8'h00, 1'b1);  // NACK ends the read
    push_cmd(OP_STOP, 8'h00, 1'b0);
    wait_idle();
    ahb_read(32'(REG_STATUS), rd);
    check_value("STATUS", rd, status_word(1, 0, 0, 0, 0, 0, 0));
    for (int i = 0; i < 3; i++) begin
      ahb_read(32'(REG_RX_DATA), rd);
      check_value($sformatf("RX_DATA[%0d]", i), rd, 32'(expected_read(i)));
    end
    ahb_read(32'(REG_STATUS), rd);
    check_value("STATUS", rd, status_word(1, 0, 1, 0, 0, 0, 0));
    finish_test(4, "read from target", errs);
  endtask

  task automatic check_address_nack();
    logic [31:0] rd;
    int unsigned errs;
    errs = errors;
    push_cmd(OP_START, 8'h00, 1'b0);
    push_cmd(OP_WRITE, {7'h46, 1'b0}, 1'b0);
    push_cmd(OP_STOP, 8'h00, 1'b0);
    wait_idle();
    ahb_read(32'(REG_STATUS), rd);
    check_value("STATUS", rd, status_word(1, 0, 1, 0, 0, 1, 0));
    ahb_write(32'(REG_STATUS), 32'h20);  // clear nack
    ahb_read(32'(REG_STATUS), rd);
    check_value("STATUS", rd, status_word(1, 0, 1, 0, 0, 0, 0));
    finish_test(5, "address NACK", errs);
  endtask

  task automatic check_command_overflow();
    logic [31:0] rd;
    int unsigned errs;
    errs = errors;
    ahb_write(32'(REG_CTRL), 32'h0);
    for (int i = 0; i < 5; i++) begin
      ahb_write(32'(REG_CMD), {21'd0, 1'b0, OP_START, 8'h00});
    end
    ahb_read(32'(REG_STATUS), rd);
    check_value("STATUS", rd, status_word(0, 1, 1, 0, 0, 0, 1));
    check_value("i3c_scl_en_o", 32'(scl_en), 32'd0);
    check_value("i3c_sda_en_o", 32'(sda_en), 32'd0);
    finish_test(6, "command overflow", errs);
  endtask

  initial begin
    int unsigned seed_ret;
    checks  = 0;
    errors  = 0;
    tests   = 0;
    aborted = 1'b0;
    reset  <= 1'b1;
    haddr  <= '0;
    htrans <= 2'b00;
    hsize  <= 3'b010;  // word
    hwrite <= 1'b0;
    hwdata <= '0;
    hsel   <= 1'b0;
    hready <= 1'b1;
    seed_ret = $urandom(98700);
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    check_reset_state();
    check_register_readback();
    write_bytes_to_target();
    read_bytes_from_target();
    check_address_nack();
    check_command_overflow();
    check_value("sva0.failures", 32'(dut0.engine0.sva0.failures), 32'd0);
    $display("tests run: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+common
common/i3c_pkg.sv
logic/sync_fifo.sv
ahb/ahb_csr_slave.sv
i3c/i3c_bus_engine.sv
logic/i3c_phy_integration_wrapper.sv
tests/i3c_target_model.sv
tests/i3c_sva.sv
tests/i3c_tb.sv

// File: Bender.yml
package:
  name: i3c_phy_integration

export_include_dirs:
  - common

sources:
  - common/i3c_pkg.sv
  - logic/sync_fifo.sv
  - ahb/ahb_csr_slave.sv
  - i3c/i3c_bus_engine.sv
  - logic/i3c_phy_integration_wrapper.sv
  - target: test
    files:
      - tests/i3c_target_model.sv
      - tests/i3c_sva.sv
      - tests/i3c_tb.sv
